// File: rtl/wb_pkg.sv
package wb_pkg;

    localparam int ADDR_W     = 32;  // linear address and eip
    localparam int SEG_W      = 16;  // segment selector
    localparam int LINE_BYTES = 16;  // one fetch line

    // operand size of a result, as encoded by decode
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2,
        size_qword = 2'd3
    } wb_size_e;

    typedef enum logic [2:0] {
        flow_none     = 3'd0,
        flow_near     = 3'd1,  // eip only, cs unchanged
        flow_jmp_far  = 3'd2,
        flow_call_far = 3'd3,
        flow_ret_far  = 3'd4,
        flow_iret     = 3'd5
    } flow_op_e;

    // opcodes that reload cs and eip together
    function automatic logic is_far_flow(flow_op_e op);
        logic far;
        case (op)
            flow_jmp_far,
            flow_call_far,
            flow_ret_far,
            flow_iret: far = 1'b1;
            default:   far = 1'b0;
        endcase
        return far;
    endfunction

endpackage

// File: rtl/wb_result_slot.sv
module wb_result_slot import wb_pkg::*; #(
    parameter int DATA_W = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid,
    input  logic              wb,
    input  logic              is_reg,
    input  logic              load_eip,
    input  logic [DATA_W-1:0] data,
    input  logic [ADDR_W-1:0] dest,
    input  wb_size_e          size,
    output logic [DATA_W-1:0] res,
    output logic [ADDR_W-1:0] res_dest,
    output wb_size_e          res_size,
    output logic              reg_w,
    output logic              mem_w
);

    logic [DATA_W-1:0] data_sized;
    logic              reg_w_nxt;
    logic              mem_w_nxt;

    always_comb begin
        case (size)
            size_byte:  data_sized = DATA_W'(data[7:0]);
            size_word:  data_sized = DATA_W'(data[15:0]);
            size_dword: data_sized = DATA_W'(data[31:0]);
            default:    data_sized = data;
        endcase
    end

    assign reg_w_nxt = valid && wb && is_reg;
    assign mem_w_nxt = valid && wb && !is_reg && !load_eip;  // eip target is never stored

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_w <= 1'b0;
            mem_w <= 1'b0;
        end else begin
            reg_w <= reg_w_nxt;
            mem_w <= mem_w_nxt;
        end
    end

    always_ff @(posedge clk) begin
        res      <= data_sized;
        res_dest <= dest;  // reg number or memory address
        res_size <= size;
    end

endmodule

// File: rtl/wb_store_select.sv
module wb_store_select import wb_pkg::*; #(
    parameter int NUM_SLOTS = 4,
    parameter int DATA_W    = 64
) (
    input  logic [NUM_SLOTS-1:0]                  slot_mem_w,
    input  logic [NUM_SLOTS*DATA_W-1:0]           slot_data,
    input  logic [NUM_SLOTS*ADDR_W-1:0]           slot_dest,
    input  logic [NUM_SLOTS*$bits(wb_size_e)-1:0] slot_size,
    output logic                                  mem_w,
    output logic [DATA_W-1:0]                     mem_data,
    output logic [ADDR_W-1:0]                     mem_adr,
    output wb_size_e                              mem_size,
    output logic                                  mem_conflict
);

    localparam int SIZE_W = $bits(wb_size_e);

    logic [NUM_SLOTS-1:0] req_low_cleared;

    // slot 1 sits in the low bits, walk downward so it wins
    always_comb begin
        mem_data = '0;
        mem_adr  = '0;
        mem_size = size_byte;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (slot_mem_w[i]) begin
                mem_data = slot_data[i*DATA_W +: DATA_W];
                mem_adr  = slot_dest[i*ADDR_W +: ADDR_W];
                mem_size = wb_size_e'(slot_size[i*SIZE_W +: SIZE_W]);
            end
        end
    end

    assign mem_w = |slot_mem_w;

    // nonzero after dropping the lowest set bit means two or more stores
    assign req_low_cleared = slot_mem_w & (slot_mem_w - NUM_SLOTS'(1));
    assign mem_conflict    = |req_low_cleared;

endmodule

// File: rtl/wb_flow_ctrl.sv
module wb_flow_ctrl import wb_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid,
    input  flow_op_e          flow_op,
    input  logic              load_eip_res1,
    input  logic              load_eip_res2,
    input  logic              load_seg_res1,
    input  logic              load_seg_res2,
    input  logic [63:0]       res1_low,
    input  logic [63:0]       res2_low,
    input  logic              br_valid_in,
    input  logic              br_taken_in,
    input  logic              br_correct_in,
    input  logic [ADDR_W-1:0] br_target,
    input  logic [ADDR_W-1:0] br_fallthrough,
    input  logic [SEG_W-1:0]  cs_in,
    input  logic              ie_in,
    input  logic [3:0]        ie_type_in,
    input  logic              interrupt_in,
    output logic [ADDR_W-1:0] fip_e,
    output logic [ADDR_W-1:0] fip_o,
    output logic [ADDR_W-1:0] eip,
    output logic              br_valid,
    output logic              br_taken,
    output logic              br_correct,
    output logic [SEG_W-1:0]  cs,
    output logic              ld_eip,
    output logic              ld_eip_cs,
    output logic [SEG_W-1:0]  seg_reg1,
    output logic [SEG_W-1:0]  seg_reg2,
    output logic              load_seg1,
    output logic              load_seg2,
    output logic              ie_val,
    output logic [3:0]        ie_type
);

    localparam int LINE_OFS = $clog2(LINE_BYTES);

    logic              far_xfer;
    logic [ADDR_W-1:0] line_base;
    logic [ADDR_W-1:0] line_next;
    logic              line_odd;
    logic [SEG_W-1:0]  seg1_sel;

    assign far_xfer  = is_far_flow(flow_op);  // includes iret
    assign line_base = {br_target[ADDR_W-1:LINE_OFS], {LINE_OFS{1'b0}}};
    assign line_next = line_base + ADDR_W'(LINE_BYTES);
    assign line_odd  = br_target[LINE_OFS];

    // far pointer carries the selector right above eip
    assign seg1_sel = far_xfer ? res1_low[ADDR_W +: SEG_W] : res1_low[SEG_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            br_valid  <= 1'b0;
            ld_eip    <= 1'b0;
            ld_eip_cs <= 1'b0;
            load_seg1 <= 1'b0;
            load_seg2 <= 1'b0;
            ie_val    <= 1'b0;
        end else begin
            br_valid  <= br_valid_in;
            ld_eip    <= valid && (load_eip_res1 || load_eip_res2);
            ld_eip_cs <= valid && far_xfer;
            load_seg1 <= valid && (load_seg_res1 || far_xfer);  // far transfer reloads cs
            load_seg2 <= valid && load_seg_res2;
            ie_val    <= ie_in || interrupt_in;  // not qualified by valid
        end
    end

    always_ff @(posedge clk) begin
        if (line_odd) begin
            fip_e <= line_next;
            fip_o <= line_base;
        end else begin
            fip_e <= line_base;
            fip_o <= line_next;
        end
        eip        <= br_taken_in ? br_target : br_fallthrough;
        br_taken   <= br_taken_in;
        br_correct <= br_correct_in;
        cs         <= cs_in;
        seg_reg1   <= seg1_sel;
        seg_reg2   <= res2_low[SEG_W-1:0];
        ie_type    <= {interrupt_in, ie_type_in[2:0]};  // msb marks external source
    end

endmodule

// File: rtl/writeback_top.sv
module writeback_top import wb_pkg::*; #(
    parameter int DATA_W    = 64,
    parameter int NUM_SLOTS = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_in,
    input  logic [DATA_W-1:0] inp1,
    input  logic              inp1_is_reg,
    input  logic [ADDR_W-1:0] inp1_dest,
    input  wb_size_e          inp1_size,
    input  logic              inp1_wb,
    input  logic [DATA_W-1:0] inp2,
    input  logic              inp2_is_reg,
    input  logic [ADDR_W-1:0] inp2_dest,
    input  wb_size_e          inp2_size,
    input  logic              inp2_wb,
    input  logic [DATA_W-1:0] inp3,
    input  logic              inp3_is_reg,
    input  logic [ADDR_W-1:0] inp3_dest,
    input  wb_size_e          inp3_size,
    input  logic              inp3_wb,
    input  logic [DATA_W-1:0] inp4,
    input  logic              inp4_is_reg,
    input  logic [ADDR_W-1:0] inp4_dest,
    input  wb_size_e          inp4_size,
    input  logic              inp4_wb,
    input  flow_op_e          flow_op,
    input  logic              load_eip_res1,
    input  logic              load_eip_res2,
    input  logic              load_seg_res1,
    input  logic              load_seg_res2,
    input  logic              br_valid_in,
    input  logic              br_taken_in,
    input  logic              br_correct_in,
    input  logic [ADDR_W-1:0] br_target,
    input  logic [ADDR_W-1:0] br_fallthrough,
    input  logic [SEG_W-1:0]  cs_in,
    input  logic              ie_in,
    input  logic [3:0]        ie_type_in,
    input  logic              interrupt_in,
    output logic              valid_out,
    output logic [DATA_W-1:0] res1,
    output logic              res1_reg_w,
    output logic [ADDR_W-1:0] res1_dest,
    output wb_size_e          res1_size,
    output logic [DATA_W-1:0] res2,
    output logic              res2_reg_w,
    output logic [ADDR_W-1:0] res2_dest,
    output wb_size_e          res2_size,
    output logic [DATA_W-1:0] res3,
    output logic              res3_reg_w,
    output logic [ADDR_W-1:0] res3_dest,
    output wb_size_e          res3_size,
    output logic [DATA_W-1:0] res4,
    output logic              res4_reg_w,
    output logic [ADDR_W-1:0] res4_dest,
    output wb_size_e          res4_size,
    output logic              mem_w,
    output logic [DATA_W-1:0] mem_data,
    output logic [ADDR_W-1:0] mem_adr,
    output wb_size_e          mem_size,
    output logic              mem_conflict,
    output logic [ADDR_W-1:0] fip_e,
    output logic [ADDR_W-1:0] fip_o,
    output logic [ADDR_W-1:0] eip,
    output logic              br_valid,
    output logic              br_taken,
    output logic              br_correct,
    output logic [SEG_W-1:0]  cs,
    output logic              ld_eip,
    output logic              ld_eip_cs,
    output logic [SEG_W-1:0]  seg_reg1,
    output logic [SEG_W-1:0]  seg_reg2,
    output logic              load_seg1,
    output logic              load_seg2,
    output logic              ie_val,
    output logic [3:0]        ie_type
);

    logic                                  res1_mem_w;
    logic                                  res2_mem_w;
    logic                                  res3_mem_w;
    logic                                  res4_mem_w;
    logic [NUM_SLOTS-1:0]                  slot_mem_w;
    logic [NUM_SLOTS*DATA_W-1:0]           slot_data;
    logic [NUM_SLOTS*ADDR_W-1:0]           slot_dest;
    logic [NUM_SLOTS*$bits(wb_size_e)-1:0] slot_size;

    wb_result_slot #(.DATA_W(DATA_W)) u_slot1 (
        .clk,
        .rst,
        .valid    (valid_in),
        .wb       (inp1_wb),
        .is_reg   (inp1_is_reg),
        .load_eip (load_eip_res1),
        .data     (inp1),
        .dest     (inp1_dest),
        .size     (inp1_size),
        .res      (res1),
        .res_dest (res1_dest),
        .res_size (res1_size),
        .reg_w    (res1_reg_w),
        .mem_w    (res1_mem_w)
    );

    wb_result_slot #(.DATA_W(DATA_W)) u_slot2 (
        .clk,
        .rst,
        .valid    (valid_in),
        .wb       (inp2_wb),
        .is_reg   (inp2_is_reg),
        .load_eip (load_eip_res2),
        .data     (inp2),
        .dest     (inp2_dest),
        .size     (inp2_size),
        .res      (res2),
        .res_dest (res2_dest),
        .res_size (res2_size),
        .reg_w    (res2_reg_w),
        .mem_w    (res2_mem_w)
    );

    wb_result_slot #(.DATA_W(DATA_W)) u_slot3 (
        .clk,
        .rst,
        .valid    (valid_in),
        .wb       (inp3_wb),
        .is_reg   (inp3_is_reg),
        .load_eip (1'b0),  // only lanes 1 and 2 carry eip
        .data     (inp3),
        .dest     (inp3_dest),
        .size     (inp3_size),
        .res      (res3),
        .res_dest (res3_dest),
        .res_size (res3_size),
        .reg_w    (res3_reg_w),
        .mem_w    (res3_mem_w)
    );

    wb_result_slot #(.DATA_W(DATA_W)) u_slot4 (
        .clk,
        .rst,
        .valid    (valid_in),
        .wb       (inp4_wb),
        .is_reg   (inp4_is_reg),
        .load_eip (1'b0),
        .data     (inp4),
        .dest     (inp4_dest),
        .size     (inp4_size),
        .res      (res4),
        .res_dest (res4_dest),
        .res_size (res4_size),
        .reg_w    (res4_reg_w),
        .mem_w    (res4_mem_w)
    );

    // slot 1 in the low bits
    assign slot_mem_w = {res4_mem_w, res3_mem_w, res2_mem_w, res1_mem_w};
    assign slot_data  = {res4, res3, res2, res1};
    assign slot_dest  = {res4_dest, res3_dest, res2_dest, res1_dest};
    assign slot_size  = {res4_size, res3_size, res2_size, res1_size};

    wb_store_select #(
        .NUM_SLOTS (NUM_SLOTS),
        .DATA_W    (DATA_W)
    ) u_store_select (
        .slot_mem_w,
        .slot_data,
        .slot_dest,
        .slot_size,
        .mem_w,
        .mem_data,
        .mem_adr,
        .mem_size,
        .mem_conflict
    );

    wb_flow_ctrl u_flow_ctrl (
        .clk,
        .rst,
        .valid    (valid_in),
        .flow_op,
        .load_eip_res1,
        .load_eip_res2,
        .load_seg_res1,
        .load_seg_res2,
        .res1_low (inp1[63:0]),  // unsized operands, raw from execute
        .res2_low (inp2[63:0]),
        .br_valid_in,
        .br_taken_in,
        .br_correct_in,
        .br_target,
        .br_fallthrough,
        .cs_in,
        .ie_in,
        .ie_type_in,
        .interrupt_in,
        .fip_e,
        .fip_o,
        .eip,
        .br_valid,
        .br_taken,
        .br_correct,
        .cs,
        .ld_eip,
        .ld_eip_cs,
        .seg_reg1,
        .seg_reg2,
        .load_seg1,
        .load_seg2,
        .ie_val,
        .ie_type
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

endmodule

// File: verif/wb_chk.sv
module wb_chk import wb_pkg::*; #(
    parameter int DATA_W = 64
) (
    input logic              clk,
    input logic              rst,
    input logic              valid_in,
    input logic [DATA_W-1:0] inp1, inp2, inp3, inp4,
    input logic              inp1_is_reg, inp2_is_reg, inp3_is_reg, inp4_is_reg,
    input logic              inp1_wb, inp2_wb, inp3_wb, inp4_wb,
    input logic [ADDR_W-1:0] inp1_dest, inp2_dest, inp3_dest, inp4_dest,
    input wb_size_e          inp1_size, inp2_size, inp3_size, inp4_size,
    input flow_op_e          flow_op,
    input logic              load_eip_res1, load_eip_res2, load_seg_res1, load_seg_res2,
    input logic              br_valid_in, br_taken_in, br_correct_in, ie_in, interrupt_in,
    input logic [ADDR_W-1:0] br_target, br_fallthrough,
    input logic [SEG_W-1:0]  cs_in,
    input logic [3:0]        ie_type_in,
    input logic              valid_out, mem_w, mem_conflict, ld_eip, ld_eip_cs,
    input logic              load_seg1, load_seg2, ie_val, br_valid, br_taken, br_correct,
    input logic              res1_reg_w, res2_reg_w, res3_reg_w, res4_reg_w,
    input logic              res1_mem_w, res2_mem_w, res3_mem_w, res4_mem_w,
    input logic [DATA_W-1:0] res1, res2, res3, res4, mem_data,
    input logic [ADDR_W-1:0] res1_dest, res2_dest, res3_dest, res4_dest,
    input wb_size_e          res1_size, res2_size, res3_size, res4_size,
    input logic [ADDR_W-1:0] mem_adr, fip_e, fip_o, eip,
    input wb_size_e          mem_size,
    input logic [SEG_W-1:0]  cs, seg_reg1, seg_reg2,
    input logic [3:0]        ie_type
);

    int                       err_count = 0;
    logic                     primed = 1'b0;  // first edge has no history yet
    logic [3:0]               reg_req;
    logic [3:0]               store_req;
    logic                     conflict_next;
    logic [DATA_W+ADDR_W+1:0] store_next;
    logic [ADDR_W-1:0]        line;
    logic                     far;
    logic [3:0]               ctrl_next;
    logic [SEG_W-1:0]         seg1_next;
    logic [4*DATA_W-1:0]      exp_res, act_res;
    logic [4*(ADDR_W+2)-1:0]  exp_tag, act_tag;
    logic [7:0]               exp_strobe, act_strobe;
    logic [DATA_W+ADDR_W+3:0] exp_store, act_store;
    logic [3*ADDR_W-1:0]      exp_fetch, act_fetch;
    logic [SEG_W+2:0]         exp_branch, act_branch;
    logic [2*SEG_W+3:0]       exp_xfer, act_xfer;
    logic [5:0]               exp_event, act_event;

    function automatic logic [DATA_W-1:0] zext(logic [DATA_W-1:0] d, wb_size_e s);
        logic [DATA_W-1:0] keep;
        case (s)
            size_byte:  keep = DATA_W'(8'hff);
            size_word:  keep = DATA_W'(16'hffff);
            size_dword: keep = DATA_W'(32'hffff_ffff);
            default:    keep = '1;
        endcase
        return d & keep;
    endfunction

    always_comb begin
        reg_req[0]   = valid_in & inp1_wb & inp1_is_reg;
        reg_req[1]   = valid_in & inp2_wb & inp2_is_reg;
        reg_req[2]   = valid_in & inp3_wb & inp3_is_reg;
        reg_req[3]   = valid_in & inp4_wb & inp4_is_reg;
        store_req[0] = valid_in & inp1_wb & ~inp1_is_reg & ~load_eip_res1;
        store_req[1] = valid_in & inp2_wb & ~inp2_is_reg & ~load_eip_res2;
        store_req[2] = valid_in & inp3_wb & ~inp3_is_reg;  // lanes 3 and 4 never load eip
        store_req[3] = valid_in & inp4_wb & ~inp4_is_reg;
        conflict_next = $countones(store_req) > 1;
        if (store_req[0]) begin
            store_next = {zext(inp1, inp1_size), inp1_dest, inp1_size};
        end else if (store_req[1]) begin
            store_next = {zext(inp2, inp2_size), inp2_dest, inp2_size};
        end else if (store_req[2]) begin
            store_next = {zext(inp3, inp3_size), inp3_dest, inp3_size};
        end else if (store_req[3]) begin
            store_next = {zext(inp4, inp4_size), inp4_dest, inp4_size};
        end else begin
            store_next = '0;
        end
        line = {br_target[ADDR_W-1:4], 4'h0};
        far  = flow_op inside {flow_jmp_far, flow_call_far, flow_ret_far, flow_iret};
        ctrl_next = {valid_in & (load_eip_res1 | load_eip_res2), valid_in & far,
                     valid_in & (load_seg_res1 | far), valid_in & load_seg_res2};
        seg1_next = far ? inp1[47:32] : inp1[15:0];
    end

    always_ff @(posedge clk) begin
        primed     <= 1'b1;
        exp_res    <= {zext(inp4, inp4_size), zext(inp3, inp3_size),
                       zext(inp2, inp2_size), zext(inp1, inp1_size)};
        exp_tag    <= {inp4_dest, inp4_size, inp3_dest, inp3_size,
                       inp2_dest, inp2_size, inp1_dest, inp1_size};
        exp_strobe <= rst ? '0 : {reg_req, store_req};
        exp_store  <= rst ? '0 : {|store_req, conflict_next, store_next};
        exp_fetch  <= {br_target[4] ? {line + 32'd16, line} : {line, line + 32'd16},
                       br_taken_in ? br_target : br_fallthrough};
        exp_branch <= {~rst & br_valid_in, br_taken_in, br_correct_in, cs_in};
        exp_xfer   <= {rst ? 4'b0 : ctrl_next, seg1_next, inp2[15:0]};
        exp_event  <= {~rst & valid_in, ~rst & (ie_in | interrupt_in), interrupt_in,
                       ie_type_in[2:0]};
    end

    assign act_res    = {res4, res3, res2, res1};
    assign act_tag    = {res4_dest, res4_size, res3_dest, res3_size,
                         res2_dest, res2_size, res1_dest, res1_size};
    assign act_strobe = {res4_reg_w, res3_reg_w, res2_reg_w, res1_reg_w,
                         res4_mem_w, res3_mem_w, res2_mem_w, res1_mem_w};
    assign act_store  = {mem_w, mem_conflict, mem_data, mem_adr, mem_size};
    assign act_fetch  = {fip_e, fip_o, eip};
    assign act_branch = {br_valid, br_taken, br_correct, cs};
    assign act_xfer   = {ld_eip, ld_eip_cs, load_seg1, load_seg2, seg_reg1, seg_reg2};
    assign act_event  = {valid_out, ie_val, ie_type};

    a_slot_results: assert property (@(posedge clk) primed |-> act_res == exp_res)
        else begin
            err_count++;
            $error("Fail slot_results expected %h actual %h", exp_res, act_res);
        end

    a_slot_tags: assert property (@(posedge clk) primed |-> act_tag == exp_tag)
        else begin
            err_count++;
            $error("Fail slot_tags expected %h actual %h", exp_tag, act_tag);
        end

    a_slot_strobes: assert property (@(posedge clk) primed |-> act_strobe == exp_strobe)
        else begin
            err_count++;
            $error("Fail slot_strobes expected %h actual %h", exp_strobe, act_strobe);
        end

    a_store_port: assert property (@(posedge clk) primed |-> act_store == exp_store)
        else begin
            err_count++;
            $error("Fail store_port expected %h actual %h", exp_store, act_store);
        end

    a_fetch_lines: assert property (@(posedge clk) primed |-> act_fetch == exp_fetch)
        else begin
            err_count++;
            $error("Fail fetch_lines expected %h actual %h", exp_fetch, act_fetch);
        end

    a_branch_state: assert property (@(posedge clk) primed |-> act_branch == exp_branch)
        else begin
            err_count++;
            $error("Fail branch_state expected %h actual %h", exp_branch, act_branch);
        end

    a_far_transfer: assert property (@(posedge clk) primed |-> act_xfer == exp_xfer)
        else begin
            err_count++;
            $error("Fail far_transfer expected %h actual %h", exp_xfer, act_xfer);
        end

    a_events: assert property (@(posedge clk) primed |-> act_event == exp_event)
        else begin
            err_count++;
            $error("Fail events expected %h actual %h", exp_event, act_event);
        end

endmodule

bind writeback_top wb_chk u_wb_chk (.*);

// File: verif/wb_tb.sv
module wb_tb import wb_pkg::*; ();

    localparam int CLK_PERIOD      = 8;
    localparam int DRIVE_DLY       = 1;
    localparam int RESET_CYCLES    = 16;
    localparam int RANDOM_CYCLES   = 400;
    localparam int DIRECTED_CYCLES = 20;  // far, iret, conflict, mid-run reset, tail
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + RANDOM_CYCLES + DIRECTED_CYCLES + 64;

    logic              clk = 1'b0;
    logic              rst;
    logic              valid_in;
    logic [63:0]       inp1, inp2, inp3, inp4;
    logic              inp1_is_reg, inp2_is_reg, inp3_is_reg, inp4_is_reg;
    logic              inp1_wb, inp2_wb, inp3_wb, inp4_wb;
    logic [ADDR_W-1:0] inp1_dest, inp2_dest, inp3_dest, inp4_dest;
    wb_size_e          inp1_size, inp2_size, inp3_size, inp4_size;
    flow_op_e          flow_op;
    logic              load_eip_res1, load_eip_res2, load_seg_res1, load_seg_res2;
    logic              br_valid_in, br_taken_in, br_correct_in;
    logic [ADDR_W-1:0] br_target, br_fallthrough;
    logic [SEG_W-1:0]  cs_in;
    logic              ie_in, interrupt_in;
    logic [3:0]        ie_type_in;
    logic              valid_out, mem_w, mem_conflict, br_valid, br_taken, br_correct;
    logic              res1_reg_w, res2_reg_w, res3_reg_w, res4_reg_w;
    logic [63:0]       res1, res2, res3, res4, mem_data;
    logic [ADDR_W-1:0] res1_dest, res2_dest, res3_dest, res4_dest;
    wb_size_e          res1_size, res2_size, res3_size, res4_size, mem_size;
    logic [ADDR_W-1:0] mem_adr, fip_e, fip_o, eip;
    logic [SEG_W-1:0]  cs, seg_reg1, seg_reg2;
    logic              ld_eip, ld_eip_cs, load_seg1, load_seg2, ie_val;
    logic [3:0]        ie_type;
    logic [31:0]       lfsr = 32'd94238;

    writeback_top #(
        .DATA_W    (64),
        .NUM_SLOTS (4)
    ) u_writeback_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], rand_bit()};
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic drive_random();
        valid_in       = rand_bit();
        inp1           = rand_bits(64);
        inp1_is_reg    = rand_bit();
        inp1_wb        = rand_bit();
        inp1_dest      = 32'(rand_bits(32));
        inp1_size      = wb_size_e'(2'(rand_bits(2)));
        inp2           = rand_bits(64);
        inp2_is_reg    = rand_bit();
        inp2_wb        = rand_bit();
        inp2_dest      = 32'(rand_bits(32));
        inp2_size      = wb_size_e'(2'(rand_bits(2)));
        inp3           = rand_bits(64);
        inp3_is_reg    = rand_bit();
        inp3_wb        = rand_bit();
        inp3_dest      = 32'(rand_bits(32));
        inp3_size      = wb_size_e'(2'(rand_bits(2)));
        inp4           = rand_bits(64);
        inp4_is_reg    = rand_bit();
        inp4_wb        = rand_bit();
        inp4_dest      = 32'(rand_bits(32));
        inp4_size      = wb_size_e'(2'(rand_bits(2)));
        flow_op        = flow_op_e'(3'(rand_bits(3) % 6));  // six legal opcodes
        load_eip_res1  = rand_bit();
        load_eip_res2  = rand_bit();
        load_seg_res1  = rand_bit();
        load_seg_res2  = rand_bit();
        br_valid_in    = rand_bit();
        br_taken_in    = rand_bit();
        br_correct_in  = rand_bit();
        br_target      = 32'(rand_bits(32));
        br_fallthrough = 32'(rand_bits(32));
        cs_in          = 16'(rand_bits(16));
        ie_in          = rand_bit();
        ie_type_in     = 4'(rand_bits(4));
        interrupt_in   = rand_bit();
    endtask

    task automatic drive_far_transfer(flow_op_e op);
        drive_random();
        valid_in      = 1'b1;
        flow_op       = op;
        load_eip_res1 = 1'b1;  // lane 1 carries the far pointer, so no store
        inp1_wb       = 1'b1;
        inp1_is_reg   = 1'b0;
        inp1          = 64'h0000_0028_0001_2350;
        br_taken_in   = 1'b1;
        br_target     = 32'h0001_2350;
        next_cycle();
    endtask

    task automatic drive_store_conflict();
        drive_random();
        valid_in      = 1'b1;
        load_eip_res1 = 1'b0;
        load_eip_res2 = 1'b0;
        inp1_wb       = 1'b1;
        inp2_wb       = 1'b1;
        inp3_wb       = 1'b1;
        inp4_wb       = 1'b1;
        inp1_is_reg   = 1'b0;
        inp2_is_reg   = 1'b0;
        inp3_is_reg   = 1'b0;
        inp4_is_reg   = 1'b0;
        next_cycle();
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired before the test sequence finished");
    end

    initial begin
        wait (u_writeback_top.u_wb_chk.err_count != 0);
        $display("Result: FAILED");
        $fatal(1, "a checker assertion failed");
    end

    initial begin
        rst = 1'b1;
        drive_random();
        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;
        repeat (RANDOM_CYCLES) begin
            drive_random();
            next_cycle();
        end
        drive_far_transfer(flow_call_far);
        drive_far_transfer(flow_iret);
        drive_store_conflict();
        drive_store_conflict();
        rst = 1'b1;
        repeat (4) begin
            drive_random();
            next_cycle();
        end
        rst = 1'b0;
        repeat (8) begin
            drive_random();
            next_cycle();
        end
        repeat (2) next_cycle();  // let the last results reach the checker
        if (u_writeback_top.u_wb_chk.err_count != 0) begin
            $display("Result: FAILED");
            $fatal(1, "checker assertions reported errors");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: project.f
rtl/wb_pkg.sv
rtl/wb_result_slot.sv
rtl/wb_store_select.sv
rtl/wb_flow_ctrl.sv
rtl/writeback_top.sv
verif/wb_chk.sv
verif/wb_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module wb_tb -f project.f -o wb_sim

out=$(./obj_dir/wb_sim) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Result: PASSED"
